//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_bundle_lanes
LOG       ?= sim.log
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f files.f -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
verilog/lanes_pkg.sv
verilog/lane_cfg_if.sv
verilog/lane_config_regs.sv
verilog/lane_engine.sv
verilog/request_arbiter.sv
verilog/response_router.sv
verilog/bundle_lanes.sv
testbench/bundle_lanes_asserts.sv
testbench/tb_bundle_lanes.sv

//--- testbench/bundle_lanes_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module bundle_lanes_asserts import lanes_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input logic                         ap_clk,
    input logic                         areset_lanes,
    input logic                         wb_stb,
    input logic                         wb_ack,
    input logic                         mem_req_valid,
    input mem_addr_t                    mem_req_addr,
    input logic [$clog2(NUM_LANES)-1:0] mem_req_id,
    input logic                         mem_req_ready,
    input logic                         done
);

    int assert_errors = 0;

    // ----------------------------------------------------------------------
    // Memory request held until taken
    // ----------------------------------------------------------------------
    assert property (@(posedge ap_clk) disable iff (areset_lanes)
        (mem_req_valid && !mem_req_ready) |=>
            (mem_req_valid && $stable(mem_req_addr) && $stable(mem_req_id)))
    else begin
        $error("memory request changed or dropped before ready");
        assert_errors++;
    end

    // Ack only inside a strobe
    assert property (@(posedge ap_clk) disable iff (areset_lanes) wb_ack |-> wb_stb)
    else begin
        $error("wb_ack high without wb_stb");
        assert_errors++;
    end

    // Bundle idle right out of reset
    assert property (@(posedge ap_clk) $fell(areset_lanes) |-> done)
    else begin
        $error("done low on the first cycle after reset");
        assert_errors++;
    end

endmodule : bundle_lanes_asserts

`default_nettype wire

//--- testbench/tb_bundle_lanes.sv
`timescale 1ns/100ps
`default_nettype none

module tb_bundle_lanes import lanes_pkg::*; #(
    parameter int NUM_LANES  = 4,
    parameter int FIFO_DEPTH = 4
) ();

    localparam int ID_W        = $clog2(NUM_LANES);
    localparam int CLK_PERIOD  = 100;
    localparam int MAX_DELAY   = 8;
    localparam int WAIT_LIMIT  = 2000;
    // Word counts of all runs below
    localparam int TOTAL_WORDS = 6 + 5 + 10 + 7 + 0;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * NUM_LANES * MAX_DELAY + 3000;

    logic            ap_clk        = 1'b0;
    logic            areset_lanes  = 1'b1;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    wb_addr_t        wb_adr;
    wb_data_t        wb_dat_w;
    wb_data_t        wb_dat_r;
    logic            wb_ack;
    logic            mem_req_valid;
    mem_addr_t       mem_req_addr;
    logic [ID_W-1:0] mem_req_id;
    logic            mem_req_ready  = 1'b0;
    logic            mem_resp_valid = 1'b0;
    logic [ID_W-1:0] mem_resp_id    = '0;
    mem_data_t       mem_resp_data  = '0;
    logic            done;

    int          error_cnt   = 0;
    int          check_cnt   = 0;
    int          cycle_cnt   = 0;
    logic [31:0] lfsr_state  = 32'h39548ae9;
    bit          lfsr_mode   = 1'b0;
    int          fixed_delay = 3;
    mem_addr_t   run_base    = '0;
    int          run_count   = 0;

    // Memory model bookkeeping
    int              req_seen [int];
    int              req_ids [$];
    int              pend_due [$];
    mem_addr_t       pend_addr [$];
    logic [ID_W-1:0] pend_id [$];

    bundle_lanes #(
        .NUM_LANES  (NUM_LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_bundle_lanes (
        .ap_clk         (ap_clk),
        .areset_lanes   (areset_lanes),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_id     (mem_req_id),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_id    (mem_resp_id),
        .mem_resp_data  (mem_resp_data),
        .done           (done)
    );

    bind bundle_lanes bundle_lanes_asserts #(.NUM_LANES(NUM_LANES)) u_bundle_lanes_asserts (
        .ap_clk        (ap_clk),
        .areset_lanes  (areset_lanes),
        .wb_stb        (wb_stb),
        .wb_ack        (wb_ack),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_id    (mem_req_id),
        .mem_req_ready (mem_req_ready),
        .done          (done)
    );

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // Memory content rule
    function automatic mem_data_t mem_word(input mem_addr_t a);
        mem_data_t w;
        w = a * 16'd3 + 16'd1;
        return w;
    endfunction

    function automatic lane_sum_t expected_sum(input mem_addr_t base, input int count,
                                               input int lane);
        lane_sum_t acc;
        mem_addr_t a;
        acc = '0;
        for (int k = 0; k < count; k++) begin
            a = base + mem_addr_t'(k * NUM_LANES + lane);
            acc = acc + lane_sum_t'(mem_word(a));
        end
        return acc;
    endfunction

    task automatic check_equal(input string what, input longint got, input longint exp);
        check_cnt++;
        assert (got == exp) else begin
            error_cnt++;
            $display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // Starts and ends on a falling edge and holds stb through the ack cycle
    task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        waited   = 0;
        @(negedge ap_clk);
        while (!wb_ack && waited < WAIT_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        assert (wb_ack) else begin
            error_cnt++;
            $display("Wishbone access to register %0d got no ack", adr);
        end
        rdata = wb_dat_r;
        @(negedge ap_clk);
        check_equal("wb_ack in the cycle after the ack", wb_ack, 0);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t wdata);
        wb_data_t unused;
        wb_access(1'b1, adr, wdata, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t rdata);
        wb_access(1'b0, adr, '0, rdata);
    endtask

    // ----------------------------------------------------------------------
    // Memory model driven on the falling edge
    // ----------------------------------------------------------------------
    always @(negedge ap_clk) begin
        logic ready;
        int   delay;
        int   offset;
        if (areset_lanes) begin
            mem_req_ready  = 1'b0;
            mem_resp_valid = 1'b0;
        end else begin
            cycle_cnt++;
            // LFSR drawn every cycle and used only in LFSR mode
            ready = (take_bits(1) == 1);
            delay = 1 + take_bits(3);
            if (!lfsr_mode) begin
                ready = 1'b1;
                delay = fixed_delay;
            end
            // Request stable until the rising edge that transfers it
            if (ready && mem_req_valid) begin
                offset = int'(mem_addr_t'(mem_req_addr - run_base));
                check_equal("request id", mem_req_id, offset % NUM_LANES);
                check_equal("request word index below count", offset / NUM_LANES < run_count, 1);
                if (req_seen.exists(int'(mem_req_addr))) begin
                    req_seen[int'(mem_req_addr)]++;
                end else begin
                    req_seen[int'(mem_req_addr)] = 1;
                end
                req_ids.push_back(int'(mem_req_id));
                pend_due.push_back(cycle_cnt + delay);
                pend_addr.push_back(mem_req_addr);
                pend_id.push_back(mem_req_id);
            end
            mem_req_ready = ready;
            if (pend_due.size() > 0 && pend_due[0] <= cycle_cnt) begin
                mem_resp_valid = 1'b1;
                mem_resp_id    = pend_id.pop_front();
                mem_resp_data  = mem_word(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end else begin
                mem_resp_valid = 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic test_after_reset();
        wb_data_t rdata;
        check_equal("done after reset", done, 1);
        check_equal("mem_req_valid after reset", mem_req_valid, 0);
        wb_read(reg_base_addr, rdata);
        check_equal("base after reset", rdata, 0);
        wb_read(reg_count_addr, rdata);
        check_equal("count after reset", rdata, 0);
        wb_read(reg_status_addr, rdata);
        check_equal("status after reset", rdata, 1);
        for (int i = 0; i < NUM_LANES; i++) begin
            wb_read(wb_addr_t'(int'(reg_sum_base_addr) + i), rdata);
            check_equal($sformatf("lane %0d sum after reset", i), rdata, 0);
        end
    endtask

    task automatic test_register_access();
        wb_data_t rdata;
        wb_write(reg_base_addr, 32'h0000_beef);
        wb_write(reg_count_addr, 32'h0000_05a3);
        wb_read(reg_base_addr, rdata);
        check_equal("base readback", rdata, 32'h0000_beef);
        wb_read(reg_count_addr, rdata);
        check_equal("count readback", rdata, 32'h0000_05a3);
    endtask

    // One kernel run followed by a check of every address and lane sum
    task automatic run_kernel(input mem_addr_t base, input int count, input bit use_lfsr);
        wb_data_t  rdata;
        mem_addr_t a;
        int        waited;
        run_base  = base;
        run_count = count;
        lfsr_mode = use_lfsr;
        req_seen.delete();
        req_ids.delete();
        wb_write(reg_base_addr, wb_data_t'(base));
        wb_write(reg_count_addr, wb_data_t'(count));
        wb_write(reg_ctrl_addr, 32'h1);
        check_equal("done after start", done, 0);
        waited = 0;
        while (!done && waited < WAIT_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        assert (done) else begin
            error_cnt++;
            $display("done did not rise within %0d cycles of start", WAIT_LIMIT);
        end
        check_equal("number of requests", req_ids.size(), count * NUM_LANES);
        for (int n = 0; n < count * NUM_LANES; n++) begin
            a = base + mem_addr_t'(n);
            check_equal($sformatf("requests to address 0x%0h", a),
                        req_seen.exists(int'(a)) ? req_seen[int'(a)] : 0, 1);
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            wb_read(wb_addr_t'(int'(reg_sum_base_addr) + i), rdata);
            check_equal($sformatf("lane %0d sum", i), rdata, expected_sum(base, count, i));
        end
        wb_read(reg_status_addr, rdata);
        check_equal("status after run", rdata, 1);
    endtask

    task automatic test_round_robin();
        logic [NUM_LANES-1:0] seen;
        run_kernel(16'h0200, 5, 1'b0);
        for (int j = 0; j + NUM_LANES <= req_ids.size(); j++) begin
            seen = '0;
            for (int m = 0; m < NUM_LANES; m++) begin
                seen[req_ids[j + m]] = 1'b1;
            end
            check_equal($sformatf("lane ids in window at request %0d", j), seen,
                        {NUM_LANES{1'b1}});
        end
    endtask

    task automatic test_restart();
        run_kernel(16'h0040, 7, 1'b0);
        // Count zero gives a quick run that clears the sums
        run_kernel(16'h0300, 0, 1'b0);
    endtask

    initial begin
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (10) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_lanes = 1'b0;
        test_after_reset();
        test_register_access();
        run_kernel(16'h0100, 6, 1'b0);
        test_round_robin();
        run_kernel(16'hfff0, 10, 1'b1);
        test_restart();
        error_cnt += u_bundle_lanes.u_bundle_lanes_asserts.assert_errors;
        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule : tb_bundle_lanes

`default_nettype wire

//--- verilog/bundle_lanes.sv
`timescale 1ns/100ps
`default_nettype none

module bundle_lanes import lanes_pkg::*; #(
    parameter int NUM_LANES  = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                         ap_clk,
    input  logic                         areset_lanes,
    // Wishbone classic
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  wb_addr_t                     wb_adr,
    input  wb_data_t                     wb_dat_w,
    output wb_data_t                     wb_dat_r,
    output logic                         wb_ack,
    // Memory request
    output logic                         mem_req_valid,
    output mem_addr_t                    mem_req_addr,
    output logic [$clog2(NUM_LANES)-1:0] mem_req_id,
    input  logic                         mem_req_ready,
    // Memory response
    input  logic                         mem_resp_valid,
    input  logic [$clog2(NUM_LANES)-1:0] mem_resp_id,
    input  mem_data_t                    mem_resp_data,
    output logic                         done
);

    // ----------------------------------------------------------------------
    // Wires
    // ----------------------------------------------------------------------
    logic [NUM_LANES-1:0] lane_req_valid;
    mem_addr_t            lane_req_addr [NUM_LANES];
    logic [NUM_LANES-1:0] lane_req_ready;
    logic [NUM_LANES-1:0] lane_resp_valid;
    mem_data_t            lane_resp_data;

    lane_cfg_if #(.NUM_LANES(NUM_LANES)) cfg_if ();

    lane_config_regs #(.NUM_LANES(NUM_LANES)) u_lane_config_regs (
        .ap_clk       (ap_clk),
        .areset_lanes (areset_lanes),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .cfg          (cfg_if.regs),
        .done         (done)
    );

    // ----------------------------------------------------------------------
    // Lanes
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lanes
        lane_engine #(
            .NUM_LANES (NUM_LANES),
            .LANE_ID   (i)
        ) u_lane_engine (
            .ap_clk       (ap_clk),
            .areset_lanes (areset_lanes),
            .cfg          (cfg_if.lanes),
            .req_valid    (lane_req_valid[i]),
            .req_addr     (lane_req_addr[i]),
            .req_ready    (lane_req_ready[i]),
            .resp_valid   (lane_resp_valid[i]),
            .resp_data    (lane_resp_data)
        );
    end

    // ----------------------------------------------------------------------
    // Shared memory port
    // ----------------------------------------------------------------------
    request_arbiter #(
        .NUM_LANES  (NUM_LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_request_arbiter (
        .ap_clk        (ap_clk),
        .areset_lanes  (areset_lanes),
        .req_valid     (lane_req_valid),
        .req_addr      (lane_req_addr),
        .req_ready     (lane_req_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_id    (mem_req_id),
        .mem_req_ready (mem_req_ready)
    );

    response_router #(.NUM_LANES(NUM_LANES)) u_response_router (
        .ap_clk          (ap_clk),
        .areset_lanes    (areset_lanes),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp_id     (mem_resp_id),
        .mem_resp_data   (mem_resp_data),
        .lane_resp_valid (lane_resp_valid),
        .lane_resp_data  (lane_resp_data)
    );

endmodule : bundle_lanes

`default_nettype wire

//--- verilog/lane_cfg_if.sv
`timescale 1ns/100ps
`default_nettype none

interface lane_cfg_if import lanes_pkg::*; #(
    parameter int NUM_LANES = 4
);

    // Descriptor broadcast to all lanes
    logic        start;
    mem_addr_t   base_addr;
    word_count_t word_count;

    // Per-lane status, one slot per lane
    logic [NUM_LANES-1:0] lane_done;
    lane_sum_t            lane_sum [NUM_LANES];

    modport regs (
        output start, base_addr, word_count,
        input  lane_done, lane_sum
    );

    modport lanes (
        input  start, base_addr, word_count,
        output lane_done, lane_sum
    );

endinterface : lane_cfg_if

`default_nettype wire

//--- verilog/lane_config_regs.sv
`timescale 1ns/100ps
`default_nettype none

module lane_config_regs import lanes_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic     ap_clk,
    input  logic     areset_lanes,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,
    lane_cfg_if.regs cfg,
    output logic     done
);

    logic     wb_req;
    logic     wb_wr;
    wb_data_t rd_data;

    // New access only when no ack is pending
    assign wb_req = wb_cyc && wb_stb && !wb_ack;
    assign wb_wr  = wb_req && wb_we;

    // ----------------------------------------------------------------------
    // Ack, start pulse, descriptor registers
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            wb_ack         <= 1'b0;
            cfg.start      <= 1'b0;
            cfg.base_addr  <= '0;
            cfg.word_count <= '0;
        end else begin
            wb_ack    <= wb_req;
            cfg.start <= wb_wr && (wb_adr == reg_ctrl_addr) && wb_dat_w[0];
            if (wb_wr && (wb_adr == reg_base_addr)) begin
                cfg.base_addr <= mem_addr_t'(wb_dat_w);
            end
            if (wb_wr && (wb_adr == reg_count_addr)) begin
                cfg.word_count <= word_count_t'(wb_dat_w);
            end
        end
    end

    // Bundle done, forced low by start so status drops right after the ack
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            done <= 1'b1;
        end else if (cfg.start) begin
            done <= 1'b0;
        end else begin
            done <= &cfg.lane_done;
        end
    end

    // ----------------------------------------------------------------------
    // Read mux
    // ----------------------------------------------------------------------
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            reg_base_addr:   rd_data = wb_data_t'(cfg.base_addr);
            reg_count_addr:  rd_data = wb_data_t'(cfg.word_count);
            reg_status_addr: rd_data = wb_data_t'(done);
            default:         rd_data = '0;
        endcase
        for (int i = 0; i < NUM_LANES; i++) begin
            if (wb_adr == wb_addr_t'(int'(reg_sum_base_addr) + i)) begin
                rd_data = cfg.lane_sum[i];
            end
        end
    end

    // Data captured with the ack
    always_ff @(posedge ap_clk) begin
        if (wb_req) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule : lane_config_regs

`default_nettype wire

//--- verilog/lane_engine.sv
`timescale 1ns/100ps
`default_nettype none

module lane_engine import lanes_pkg::*; #(
    parameter int NUM_LANES = 4,
    parameter int LANE_ID   = 0
) (
    input  logic      ap_clk,
    input  logic      areset_lanes,
    lane_cfg_if.lanes cfg,
    output logic      req_valid,
    output mem_addr_t req_addr,
    input  logic      req_ready,
    input  logic      resp_valid,
    input  mem_data_t resp_data
);

    logic        done_q;
    word_count_t count_q;
    word_count_t issue_cnt;
    word_count_t rcv_cnt;
    mem_addr_t   next_addr;
    lane_sum_t   sum_q;

    // Requests pending while running and not all issued
    assign req_valid = !done_q && (issue_cnt != count_q);
    assign req_addr  = next_addr;

    assign cfg.lane_done[LANE_ID] = done_q;
    assign cfg.lane_sum[LANE_ID]  = sum_q;

    // ----------------------------------------------------------------------
    // Issue and receive counters
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            done_q    <= 1'b1;
            issue_cnt <= '0;
            rcv_cnt   <= '0;
        end else if (cfg.start) begin
            done_q    <= 1'b0;
            issue_cnt <= '0;
            rcv_cnt   <= '0;
        end else begin
            if (req_valid && req_ready) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
            if (resp_valid) begin
                rcv_cnt <= rcv_cnt + 1'b1;
            end
            // Last word already in the sum
            if (!done_q && (rcv_cnt == count_q)) begin
                done_q <= 1'b1;
            end
        end
    end

    // Strided address: base + k * NUM_LANES + LANE_ID
    always_ff @(posedge ap_clk) begin
        if (cfg.start) begin
            count_q   <= cfg.word_count;
            next_addr <= cfg.base_addr + mem_addr_t'(LANE_ID);
        end else if (req_valid && req_ready) begin
            next_addr <= next_addr + mem_addr_t'(NUM_LANES);
        end
    end

    // Accumulator
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            sum_q <= '0;
        end else if (cfg.start) begin
            sum_q <= '0;
        end else if (resp_valid) begin
            sum_q <= sum_q + lane_sum_t'(resp_data);
        end
    end

endmodule : lane_engine

`default_nettype wire

//--- verilog/lanes_pkg.sv
`default_nettype none

package lanes_pkg;

    // ----------------------------------------------------------------------
    // Widths with a meaning
    // ----------------------------------------------------------------------
    typedef logic [15:0] mem_addr_t;
    typedef logic [15:0] mem_data_t;
    typedef logic [31:0] lane_sum_t;
    typedef logic [11:0] word_count_t;
    typedef logic [3:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // ----------------------------------------------------------------------
    // Register map, word addresses
    // ----------------------------------------------------------------------
    // Bit 0 is start, write only
    localparam wb_addr_t reg_ctrl_addr     = 4'd0;
    localparam wb_addr_t reg_base_addr     = 4'd1;
    localparam wb_addr_t reg_count_addr    = 4'd2;
    // Bit 0 is done
    localparam wb_addr_t reg_status_addr   = 4'd3;
    // Lane i sum at reg_sum_base_addr + i
    localparam wb_addr_t reg_sum_base_addr = 4'd4;

    // Arbiter grant holding stage in front of the request FIFO
    typedef enum logic {
        arb_idle,
        arb_hold
    } arb_state_t;

endpackage : lanes_pkg

`default_nettype wire

//--- verilog/request_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module request_arbiter import lanes_pkg::*; #(
    parameter int NUM_LANES  = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                         ap_clk,
    input  logic                         areset_lanes,
    input  logic [NUM_LANES-1:0]         req_valid,
    input  mem_addr_t                    req_addr [NUM_LANES],
    output logic [NUM_LANES-1:0]         req_ready,
    output logic                         mem_req_valid,
    output mem_addr_t                    mem_req_addr,
    output logic [$clog2(NUM_LANES)-1:0] mem_req_id,
    input  logic                         mem_req_ready
);

    localparam int ID_W  = $clog2(NUM_LANES);
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [ID_W-1:0] lane_id_t;

    arb_state_t state;
    lane_id_t   last_grant;
    lane_id_t   grant_idx;
    logic       grant_found;
    logic       grant_en;
    mem_addr_t  hold_addr;
    lane_id_t   hold_id;

    mem_addr_t        fifo_addr [FIFO_DEPTH];
    lane_id_t         fifo_id   [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_cnt;
    logic             fifo_full;
    logic             fifo_wr;
    logic             fifo_rd;

    // ----------------------------------------------------------------------
    // Round-robin search, starting after the last granted lane
    // ----------------------------------------------------------------------
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_idx   = last_grant;
        for (int k = 1; k <= NUM_LANES; k++) begin
            idx = (int'(last_grant) + k) % NUM_LANES;
            if (!grant_found && req_valid[idx]) begin
                grant_found = 1'b1;
                grant_idx   = lane_id_t'(idx);
            end
        end
    end

    // Held grant drains this cycle when the FIFO has room
    assign fifo_full = (fifo_cnt == CNT_W'(FIFO_DEPTH));
    assign fifo_wr   = (state == arb_hold) && !fifo_full;
    assign grant_en  = grant_found && !fifo_full;

    always_comb begin
        req_ready = '0;
        if (grant_en) begin
            req_ready[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            state      <= arb_idle;
            last_grant <= lane_id_t'(NUM_LANES - 1);
        end else begin
            if (grant_en) begin
                last_grant <= grant_idx;
            end
            case (state)
                arb_idle: if (grant_en) state <= arb_hold;
                arb_hold: if (fifo_wr && !grant_en) state <= arb_idle;
                default:  state <= arb_idle;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (grant_en) begin
            hold_addr <= req_addr[grant_idx];
            hold_id   <= grant_idx;
        end
    end

    // ----------------------------------------------------------------------
    // Request FIFO toward memory
    // ----------------------------------------------------------------------
    assign mem_req_valid = (fifo_cnt != '0);
    assign mem_req_addr  = fifo_addr[rd_ptr];
    assign mem_req_id    = fifo_id[rd_ptr];
    assign fifo_rd       = mem_req_valid && mem_req_ready;

    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (fifo_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({fifo_wr, fifo_rd})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (fifo_wr) begin
            fifo_addr[wr_ptr] <= hold_addr;
            fifo_id[wr_ptr]   <= hold_id;
        end
    end

endmodule : request_arbiter

`default_nettype wire

//--- verilog/response_router.sv
`timescale 1ns/100ps
`default_nettype none

module response_router import lanes_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                         ap_clk,
    input  logic                         areset_lanes,
    input  logic                         mem_resp_valid,
    input  logic [$clog2(NUM_LANES)-1:0] mem_resp_id,
    input  mem_data_t                    mem_resp_data,
    output logic [NUM_LANES-1:0]         lane_resp_valid,
    output mem_data_t                    lane_resp_data
);

    localparam int ID_W = $clog2(NUM_LANES);

    typedef logic [ID_W-1:0] lane_id_t;

    // One-hot valid by lane id
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            lane_resp_valid <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                lane_resp_valid[i] <= mem_resp_valid && (mem_resp_id == lane_id_t'(i));
            end
        end
    end

    // Data shared by all lanes, qualified by the valids above
    always_ff @(posedge ap_clk) begin
        lane_resp_data <= mem_resp_data;
    end

endmodule : response_router

`default_nettype wire
